// File: all.f
engine_pkg.sv
memory_pkg.sv
rw_kernel.sv
rw_engine.sv
mem_arbiter.sv
scratch_memory.sv
graph_rw_top.sv
graph_rw_assertions.sv
tb_graph_rw.sv

// File: engine_pkg.sv
// Engine-side type definitions for the graph read/write slice
// Packet layout, per-field sequence state and the static engine configuration
// Referenced by scoped name from the kernel, engine, top level and testbench

package engine_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int num_fields  = 4;
  localparam int field_w     = 32;
  localparam int num_engines = 2;

  // ------------------------------
  // Packet
  // ------------------------------
  typedef enum logic [1:0] {
    seq_invalid = 2'd0,
    seq_running = 2'd1,
    seq_done    = 2'd2
  } field_state_t;

  typedef struct packed {
    logic [num_fields-1:0][field_w-1:0] field;
    field_state_t [num_fields-1:0]      field_state;
  } engine_packet_t;

  // ------------------------------
  // Configuration
  // ------------------------------
  // ops_mask row i picks the source field for destination i,
  // the highest set bit wins when several are set
  typedef struct packed {
    logic [num_fields-1:0]                 const_mask;
    logic [num_fields-1:0][num_fields-1:0] ops_mask;
    logic [field_w-1:0]                    const_value;
    logic [field_w-1:0]                    index_start;
    logic [4:0]                            granularity;
    logic                                  direction;   // 1 shifts left
    logic                                  mode_write;  // 1 writes field 0
  } engine_config_t;

endpackage

// File: graph_rw_assertions.sv
// Concurrent protocol checks for the read/write slice
// Bound into every rw_engine and into mem_arbiter, unused inputs are tied off
// Covers request hold, output hold, grant count and read response routing

module graph_rw_assertions (
  input logic                                             ap_clk,
  input logic                                             rst_n,
  input memory_pkg::mem_req_t [engine_pkg::num_engines-1:0] req,
  input logic [engine_pkg::num_engines-1:0]               req_valid,
  input logic [engine_pkg::num_engines-1:0]               req_ready,
  input logic [engine_pkg::num_engines-1:0]               rsp_valid,
  input logic                                             out_valid,
  input logic                                             out_ready,
  input engine_pkg::engine_packet_t                       pkt_out
);

  // Failed checks in this instance
  int fail_count = 0;

  for (genvar k = 0; k < engine_pkg::num_engines; k++) begin : lane
    // Request held with unchanged payload until granted
    req_hold_a: assert property (@(posedge ap_clk) disable iff (!rst_n)
      req_valid[k] && !req_ready[k] |=> req_valid[k] && $stable(req[k]))
      else begin
        $error("request %0d dropped or changed before its grant", k);
        fail_count++;
      end

    // Response exactly one cycle after a read grant to the same engine
    rsp_time_a: assert property (@(posedge ap_clk) disable iff (!rst_n)
      rsp_valid[k] == $past(req_valid[k] && req_ready[k] && !req[k].write))
      else begin
        $error("read response for engine %0d not one cycle after its read grant", k);
        fail_count++;
      end
  end

  out_hold_a: assert property (@(posedge ap_clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(pkt_out))
    else begin
      $error("output packet dropped or changed before out_ready");
      fail_count++;
    end

  one_grant_a: assert property (@(posedge ap_clk) disable iff (!rst_n) $onehot0(req_ready))
    else begin
      $error("more than one grant in a cycle");
      fail_count++;
    end

  grant_req_a: assert property (@(posedge ap_clk) disable iff (!rst_n)
    (req_ready & ~req_valid) == '0)
    else begin
      $error("grant given without a request");
      fail_count++;
    end

endmodule

bind rw_engine graph_rw_assertions engine_chk_i (
  .ap_clk (ap_clk), .rst_n (rst_n), .req ({2{req}}),
  .req_valid ({1'b0, req_valid}), .req_ready ({1'b0, req_ready}),
  .rsp_valid ({1'b0, rsp_valid}),
  .out_valid (out_valid), .out_ready (out_ready), .pkt_out (pkt_out)
);

bind mem_arbiter graph_rw_assertions arbiter_chk_i (
  .ap_clk (ap_clk), .rst_n (rst_n), .req (req), .req_valid (req_valid),
  .req_ready (req_ready), .rsp_valid (rsp_valid),
  .out_valid (1'b0), .out_ready (1'b1), .pkt_out ('0)
);

// File: graph_rw_top.sv
// Top level of the read/write slice
// Two peer engines share one scratch memory through the round-robin arbiter
// Engine A is arbiter port 0, engine B is port 1

module graph_rw_top (
  input  logic                       ap_clk,
  input  logic                       rst_n,
  input  engine_pkg::engine_config_t cfg_a,
  input  engine_pkg::engine_config_t cfg_b,
  input  engine_pkg::engine_packet_t pkt_in_a,
  input  logic                       in_valid_a,
  input  engine_pkg::engine_packet_t pkt_in_b,
  input  logic                       in_valid_b,
  input  logic                       out_ready_a,
  input  logic                       out_ready_b,
  output logic                       in_ready_a,
  output logic                       in_ready_b,
  output engine_pkg::engine_packet_t pkt_out_a,
  output logic                       out_valid_a,
  output engine_pkg::engine_packet_t pkt_out_b,
  output logic                       out_valid_b
);

  memory_pkg::mem_req_t [engine_pkg::num_engines-1:0] req;
  logic [engine_pkg::num_engines-1:0]                 req_valid;
  logic [engine_pkg::num_engines-1:0]                 req_ready;
  logic [engine_pkg::num_engines-1:0]                 rsp_valid;
  memory_pkg::mem_rsp_t                               rsp;
  memory_pkg::mem_req_t                               mem_req;
  logic                                               mem_req_valid;
  memory_pkg::mem_rsp_t                               mem_rsp;

  rw_engine engine_a_i (
    .ap_clk (ap_clk), .rst_n (rst_n), .cfg (cfg_a),
    .pkt_in (pkt_in_a), .in_valid (in_valid_a), .out_ready (out_ready_a),
    .req_ready (req_ready[0]), .rsp (rsp), .rsp_valid (rsp_valid[0]),
    .in_ready (in_ready_a), .pkt_out (pkt_out_a), .out_valid (out_valid_a),
    .req (req[0]), .req_valid (req_valid[0])
  );

  rw_engine engine_b_i (
    .ap_clk (ap_clk), .rst_n (rst_n), .cfg (cfg_b),
    .pkt_in (pkt_in_b), .in_valid (in_valid_b), .out_ready (out_ready_b),
    .req_ready (req_ready[1]), .rsp (rsp), .rsp_valid (rsp_valid[1]),
    .in_ready (in_ready_b), .pkt_out (pkt_out_b), .out_valid (out_valid_b),
    .req (req[1]), .req_valid (req_valid[1])
  );

  mem_arbiter arbiter_i (
    .ap_clk (ap_clk), .rst_n (rst_n), .req (req), .req_valid (req_valid),
    .mem_rsp (mem_rsp), .req_ready (req_ready), .mem_req (mem_req),
    .mem_req_valid (mem_req_valid), .rsp (rsp), .rsp_valid (rsp_valid)
  );

  scratch_memory memory_i (
    .ap_clk (ap_clk), .mem_req (mem_req), .mem_req_valid (mem_req_valid),
    .mem_rsp (mem_rsp)
  );

endmodule

// File: mem_arbiter.sv
// Round-robin arbiter between engine memory requests
// Grant is combinational from the request valids, priority moves past the
// granted engine, and a read response is steered by the registered grant id

module mem_arbiter (
  input  logic                                            ap_clk,
  input  logic                                            rst_n,
  input  memory_pkg::mem_req_t [engine_pkg::num_engines-1:0] req,
  input  logic [engine_pkg::num_engines-1:0]              req_valid,
  input  memory_pkg::mem_rsp_t                            mem_rsp,
  output logic [engine_pkg::num_engines-1:0]              req_ready,
  output memory_pkg::mem_req_t                            mem_req,
  output logic                                            mem_req_valid,
  output memory_pkg::mem_rsp_t                            rsp,
  output logic [engine_pkg::num_engines-1:0]              rsp_valid
);

  // Engine that has first priority this cycle, engine 0 after reset
  logic [memory_pkg::engine_id_w-1:0] next_prio;
  logic [memory_pkg::engine_id_w-1:0] grant_id;
  logic [memory_pkg::engine_id_w-1:0] rd_id;
  logic                               grant_any;
  logic                               rd_pending;
  int                                 cand;

  // ------------------------------
  // Grant selection
  // ------------------------------
  always_comb begin
    grant_any = 1'b0;
    grant_id  = next_prio;
    for (int i = 0; i < engine_pkg::num_engines; i++) begin
      cand = (int'(next_prio) + i) % engine_pkg::num_engines;
      if (!grant_any && req_valid[cand]) begin
        grant_any = 1'b1;
        grant_id  = cand[memory_pkg::engine_id_w-1:0];
      end
    end
  end

  always_comb begin
    for (int k = 0; k < engine_pkg::num_engines; k++) begin
      req_ready[k] = grant_any && (int'(grant_id) == k);
      rsp_valid[k] = rd_pending && (int'(rd_id) == k);
    end
  end

  assign mem_req       = req[grant_id];
  assign mem_req_valid = grant_any;
  assign rsp           = mem_rsp;

  always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
      next_prio  <= '0;
      rd_pending <= 1'b0;
    end else begin
      rd_pending <= grant_any && !mem_req.write;
      if (grant_any) begin
        if (int'(grant_id) == engine_pkg::num_engines - 1) next_prio <= '0;
        else next_prio <= grant_id + 1'b1;
      end
    end
  end

  // Remembers who gets the read data next cycle
  always_ff @(posedge ap_clk) begin
    if (grant_any) rd_id <= grant_id;
  end

endmodule

// File: memory_pkg.sv
// Scratch memory interface definitions
// Request and response words exchanged between engines, arbiter and memory
// The write data width follows the engine field width

package memory_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int mem_depth   = 256;
  localparam int mem_addr_w  = 8;
  localparam int engine_id_w = 1;

  // ------------------------------
  // Request and response
  // ------------------------------
  // Address is the low mem_addr_w bits of the scaled offset
  typedef struct packed {
    logic [mem_addr_w-1:0]          addr;
    logic [engine_pkg::field_w-1:0] wdata;
    logic                           write;
  } mem_req_t;

  typedef struct packed {
    logic [engine_pkg::field_w-1:0] rdata;
  } mem_rsp_t;

endpackage

// File: rw_engine.sv
// Read/write engine
// Takes one kernel result at a time, performs its single memory access
// through the arbiter and offers the finished packet downstream
// A write stores field 0, a read replaces field 0 and marks it done

module rw_engine (
  input  logic                       ap_clk,
  input  logic                       rst_n,
  input  engine_pkg::engine_config_t cfg,
  input  engine_pkg::engine_packet_t pkt_in,
  input  logic                       in_valid,
  input  logic                       out_ready,
  input  logic                       req_ready,
  input  memory_pkg::mem_rsp_t       rsp,
  input  logic                       rsp_valid,
  output logic                       in_ready,
  output engine_pkg::engine_packet_t pkt_out,
  output logic                       out_valid,
  output memory_pkg::mem_req_t       req,
  output logic                       req_valid
);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait_read,
    st_present
  } state_t;

  state_t                            state;
  logic                              k_out_ready;
  logic                              k_out_valid;
  engine_pkg::engine_packet_t        k_pkt;
  logic [memory_pkg::mem_addr_w-1:0] k_addr;
  engine_pkg::engine_packet_t        hold_pkt;
  logic [memory_pkg::mem_addr_w-1:0] hold_addr;

  rw_kernel kernel_i (
    .ap_clk    (ap_clk),
    .rst_n     (rst_n),
    .cfg       (cfg),
    .pkt_in    (pkt_in),
    .in_valid  (in_valid),
    .out_ready (k_out_ready),
    .in_ready  (in_ready),
    .addr      (k_addr),
    .pkt_out   (k_pkt),
    .out_valid (k_out_valid)
  );

  // Kernel drains only while no access is in progress
  assign k_out_ready = (state == st_idle);

  assign req.addr  = hold_addr;
  assign req.wdata = hold_pkt.field[0];
  assign req.write = cfg.mode_write;
  assign req_valid = (state == st_request);
  assign out_valid = (state == st_present);
  assign pkt_out   = hold_pkt;

  // ------------------------------
  // Access FSM
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (k_out_valid) state <= st_request;
        end
        st_request: begin
          if (req_ready) state <= cfg.mode_write ? st_present : st_wait_read;
        end
        st_wait_read: begin
          if (rsp_valid) state <= st_present;
        end
        default: begin
          if (out_ready) state <= st_idle;
        end
      endcase
    end
  end

  // Packet capture and read merge
  always_ff @(posedge ap_clk) begin
    if (state == st_idle && k_out_valid) begin
      hold_pkt  <= k_pkt;
      hold_addr <= k_addr;
    end else if (state == st_wait_read && rsp_valid) begin
      hold_pkt.field[0]       <= rsp.rdata;
      hold_pkt.field_state[0] <= engine_pkg::seq_done;
    end
  end

endmodule

// File: rw_kernel.sv
// Read/write kernel, three registered stages
// Stage 1 rebuilds the packet from fields and constants, stage 2 scales the
// word address, stage 3 presents packet and address with a valid bit
// All stages stall together when the output is held

module rw_kernel (
  input  logic                            ap_clk,
  input  logic                            rst_n,
  input  engine_pkg::engine_config_t      cfg,
  input  engine_pkg::engine_packet_t      pkt_in,
  input  logic                            in_valid,
  input  logic                            out_ready,
  output logic                            in_ready,
  output logic [memory_pkg::mem_addr_w-1:0] addr,
  output engine_pkg::engine_packet_t      pkt_out,
  output logic                            out_valid
);

  logic                                advance;
  logic                                s1_valid;
  logic                                s2_valid;
  engine_pkg::engine_packet_t          s1_pkt;
  engine_pkg::engine_packet_t          s2_pkt;
  engine_pkg::engine_config_t          cfg_s1;
  logic [memory_pkg::mem_addr_w-1:0]   s2_addr;
  logic [engine_pkg::field_w-1:0]      offset_sum;
  logic [engine_pkg::field_w-1:0]      offset_scaled;

  // Field selection, constants first, then the highest ops_mask bit
  function automatic engine_pkg::engine_packet_t select_fields(
    input engine_pkg::engine_config_t c,
    input engine_pkg::engine_packet_t p
  );
    engine_pkg::engine_packet_t r;
    for (int i = 0; i < engine_pkg::num_fields; i++) begin
      r.field[i]       = '0;
      r.field_state[i] = engine_pkg::seq_invalid;
      for (int j = 0; j < engine_pkg::num_fields; j++) begin
        if (c.ops_mask[i][j]) begin
          r.field[i]       = p.field[j];
          r.field_state[i] = p.field_state[j];
        end
      end
      if (c.const_mask[i]) begin
        r.field[i]       = c.const_value;
        r.field_state[i] = engine_pkg::seq_running;
      end
    end
    return r;
  endfunction

  // One stall condition freezes the whole pipe
  assign advance  = !(out_valid && !out_ready);
  assign in_ready = advance;

  // Field 1 of the rebuilt packet is the index offset
  always_comb begin
    offset_sum = cfg_s1.index_start + s1_pkt.field[1];
    if (cfg_s1.direction) begin
      offset_scaled = offset_sum << cfg_s1.granularity;
    end else begin
      offset_scaled = offset_sum >> cfg_s1.granularity;
    end
  end

  // ------------------------------
  // Valid chain
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else if (advance) begin
      s1_valid  <= in_valid;
      s2_valid  <= s1_valid;
      out_valid <= s2_valid;
    end
  end

  // ------------------------------
  // Payload stages
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (advance) begin
      s1_pkt  <= select_fields(cfg, pkt_in);
      cfg_s1  <= cfg;
      s2_pkt  <= s1_pkt;
      s2_addr <= offset_scaled[memory_pkg::mem_addr_w-1:0];
      pkt_out <= s2_pkt;
      addr    <= s2_addr;
    end
  end

endmodule

// File: scratch_memory.sv
// Shared scratch memory, single port, one word per access
// Writes land on the grant edge, read data is registered and valid one
// cycle after the request

module scratch_memory (
  input  logic                 ap_clk,
  input  memory_pkg::mem_req_t mem_req,
  input  logic                 mem_req_valid,
  output memory_pkg::mem_rsp_t mem_rsp
);

  logic [engine_pkg::field_w-1:0] mem [memory_pkg::mem_depth];

  // ------------------------------
  // Storage port
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (mem_req_valid) begin
      if (mem_req.write) begin
        mem[mem_req.addr] <= mem_req.wdata;
      end else begin
        mem_rsp.rdata <= mem[mem_req.addr];
      end
    end
  end

endmodule

// File: tb_graph_rw.sv
// Testbench for the graph read/write slice
// A table of packets and engine configurations is applied group by group,
// with both engines streaming inside a group. Expected packets come from a
// selection and address model with a shadow copy of the scratch memory.
// Outputs are checked in order per engine, the timing is left free

module tb_graph_rw;

  localparam int period      = 40;
  localparam int drive_delay = 5;
  localparam int last_group  = 11;

  typedef struct packed {
    logic                       eng;
    int                         grp;
    logic                       stall;
    engine_pkg::engine_config_t cfg;
    engine_pkg::engine_packet_t pkt;
  } entry_t;

  typedef struct packed {
    int                         idx;
    engine_pkg::engine_packet_t pkt;
  } expect_t;

  logic                       ap_clk;
  logic                       rst_n;
  engine_pkg::engine_config_t cfg_a;
  engine_pkg::engine_config_t cfg_b;
  engine_pkg::engine_packet_t pkt_in_a;
  engine_pkg::engine_packet_t pkt_in_b;
  logic                       in_valid_a;
  logic                       in_valid_b;
  logic                       out_ready_a;
  logic                       out_ready_b;
  logic                       in_ready_a;
  logic                       in_ready_b;
  engine_pkg::engine_packet_t pkt_out_a;
  engine_pkg::engine_packet_t pkt_out_b;
  logic                       out_valid_a;
  logic                       out_valid_b;

  entry_t                         entries[$];
  expect_t                        exp_a[$];
  expect_t                        exp_b[$];
  logic [engine_pkg::field_w-1:0] shadow [memory_pkg::mem_depth];
  integer                         seed;
  logic [31:0]                    rnd_word;
  logic                           stall_a;
  logic                           stall_b;
  logic                           table_ready = 1'b0;
  int                             tests_run = 0;
  int                             tests_failed = 0;
  int                             error_count = 0;

  graph_rw_top dut_i (
    .ap_clk (ap_clk), .rst_n (rst_n), .cfg_a (cfg_a), .cfg_b (cfg_b),
    .pkt_in_a (pkt_in_a), .in_valid_a (in_valid_a),
    .pkt_in_b (pkt_in_b), .in_valid_b (in_valid_b),
    .out_ready_a (out_ready_a), .out_ready_b (out_ready_b),
    .in_ready_a (in_ready_a), .in_ready_b (in_ready_b),
    .pkt_out_a (pkt_out_a), .out_valid_a (out_valid_a),
    .pkt_out_b (pkt_out_b), .out_valid_b (out_valid_b)
  );

  always #(period / 2) ap_clk = ~ap_clk;

  // ------------------------------
  // Reference model
  // ------------------------------
  function automatic engine_pkg::engine_config_t make_cfg(
    input logic [engine_pkg::num_fields-1:0]                      const_mask,
    input logic [engine_pkg::num_fields*engine_pkg::num_fields-1:0] ops_mask,
    input logic [engine_pkg::field_w-1:0]                         const_value,
    input logic [engine_pkg::field_w-1:0]                         index_start,
    input logic [4:0]                                             granularity,
    input logic                                                   direction,
    input logic                                                   mode_write
  );
    engine_pkg::engine_config_t c;
    c.const_mask  = const_mask;
    c.ops_mask    = ops_mask;
    c.const_value = const_value;
    c.index_start = index_start;
    c.granularity = granularity;
    c.direction   = direction;
    c.mode_write  = mode_write;
    return c;
  endfunction

  // Constant first, else highest set ops bit, else zero and invalid
  function automatic engine_pkg::engine_packet_t select_ref(
    input engine_pkg::engine_config_t c,
    input engine_pkg::engine_packet_t p
  );
    engine_pkg::engine_packet_t r;
    int src;
    for (int i = 0; i < engine_pkg::num_fields; i++) begin
      src = -1;
      for (int j = engine_pkg::num_fields - 1; j >= 0; j--) begin
        if (src < 0 && c.ops_mask[i][j]) begin
          src = j;
        end
      end
      if (c.const_mask[i]) begin
        r.field[i]       = c.const_value;
        r.field_state[i] = engine_pkg::seq_running;
      end else if (src >= 0) begin
        r.field[i]       = p.field[src];
        r.field_state[i] = p.field_state[src];
      end else begin
        r.field[i]       = '0;
        r.field_state[i] = engine_pkg::seq_invalid;
      end
    end
    return r;
  endfunction

  function automatic logic [memory_pkg::mem_addr_w-1:0] addr_ref(
    input engine_pkg::engine_config_t c,
    input engine_pkg::engine_packet_t sel
  );
    logic [engine_pkg::field_w-1:0] offset;
    offset = c.index_start + sel.field[1];
    offset = c.direction ? (offset << c.granularity) : (offset >> c.granularity);
    return offset[memory_pkg::mem_addr_w-1:0];
  endfunction

  // Table order inside a group is the per-engine output order
  task automatic predict_group(input int g);
    engine_pkg::engine_packet_t        sel;
    logic [memory_pkg::mem_addr_w-1:0] a;
    expect_t                           e;
    for (int i = 0; i < entries.size(); i++) begin
      if (entries[i].grp == g) begin
        sel = select_ref(entries[i].cfg, entries[i].pkt);
        a   = addr_ref(entries[i].cfg, sel);
        if (entries[i].cfg.mode_write) begin
          shadow[a] = sel.field[0];
        end else begin
          sel.field[0]       = shadow[a];
          sel.field_state[0] = engine_pkg::seq_done;
        end
        e.idx = i;
        e.pkt = sel;
        if (entries[i].eng) exp_b.push_back(e);
        else exp_a.push_back(e);
      end
    end
  endtask

  // Failed protocol assertions in the bound checkers
  function automatic int assertion_failures();
    return dut_i.engine_a_i.engine_chk_i.fail_count
         + dut_i.engine_b_i.engine_chk_i.fail_count
         + dut_i.arbiter_i.arbiter_chk_i.fail_count;
  endfunction

  // ------------------------------
  // Stimulus table
  // ------------------------------
  task automatic add_entries(input logic eng, input int grp, input logic stall,
                             input engine_pkg::engine_config_t cfg, input int count);
    entry_t      e;
    logic [31:0] word;
    for (int n = 0; n < count; n++) begin
      e.eng   = eng;
      e.grp   = grp;
      e.stall = stall;
      e.cfg   = cfg;
      for (int f = 0; f < engine_pkg::num_fields; f++) begin
        e.pkt.field[f]       = $random(seed);
        word                 = $random(seed);
        e.pkt.field_state[f] = engine_pkg::field_state_t'(word % 3);
      end
      entries.push_back(e);
    end
  endtask

  task automatic build_table();
    // Selection mixes, writes to scattered words
    add_entries(0, 0, 0, make_cfg(4'b0000, 16'h8421, 32'h0, 32'h0, 5'd0, 1, 1), 2);
    add_entries(0, 1, 1, make_cfg(4'b0100, 16'h0f30, 32'hdead_beef, 32'h10, 5'd2, 0, 1), 2);
    add_entries(1, 2, 0, make_cfg(4'b1001, 16'h1e6c, 32'h55, 32'h7, 5'd1, 1, 1), 2);
    // Writes through A, reads of the same words through B
    add_entries(0, 3, 0, make_cfg(4'b0010, 16'h0001, 32'h2, 32'h3, 5'd2, 1, 1), 1);
    add_entries(0, 4, 0, make_cfg(4'b0010, 16'h0004, 32'h100, 32'hf00, 5'd6, 0, 1), 1);
    add_entries(1, 5, 0, make_cfg(4'b0010, 16'h8401, 32'h0, 32'h140, 5'd4, 0, 0), 1);
    add_entries(1, 6, 0, make_cfg(4'b0010, 16'h0008, 32'h1, 32'h1f, 5'd1, 1, 0), 1);
    add_entries(0, 7, 1, make_cfg(4'b0010, 16'h4000, 32'h4, 32'h1, 5'd2, 1, 0), 2);
    // Both engines at once, never the same word within one group
    add_entries(0, 8, 0, make_cfg(4'b0010, 16'h0002, 32'h0, 32'h60, 5'd0, 1, 1), 4);
    add_entries(1, 8, 0, make_cfg(4'b0010, 16'h0421, 32'h4, 32'h1, 5'd2, 1, 0), 4);
    add_entries(0, 9, 1, make_cfg(4'b0010, 16'h8001, 32'hc0, 32'h0, 5'd1, 0, 0), 3);
    add_entries(1, 9, 1, make_cfg(4'b0010, 16'h0002, 32'h8, 32'h8, 5'd3, 1, 1), 3);
    add_entries(0, 10, 1, make_cfg(4'b0010, 16'h0008, 32'hc8, 32'h0, 5'd0, 0, 1), 3);
    add_entries(1, 10, 1, make_cfg(4'b0010, 16'h8421, 32'h400, 32'h0, 5'd3, 0, 0), 3);
    add_entries(0, 11, 0, make_cfg(4'b0010, 16'h2000, 32'h32, 32'h0, 5'd2, 1, 0), 2);
    add_entries(1, 11, 0, make_cfg(4'b0010, 16'h0000, 32'h30, 32'h0, 5'd1, 1, 0), 2);
  endtask

  // ------------------------------
  // Drivers and output checks
  // ------------------------------
  task automatic drive_input(input logic eng, input entry_t e, input logic v);
    if (!eng) begin
      cfg_a      = e.cfg;
      pkt_in_a   = e.pkt;
      stall_a    = e.stall;
      in_valid_a = v;
    end else begin
      cfg_b      = e.cfg;
      pkt_in_b   = e.pkt;
      stall_b    = e.stall;
      in_valid_b = v;
    end
  endtask

  task automatic stream(input logic eng, input int g);
    for (int i = 0; i < entries.size(); i++) begin
      if (entries[i].grp == g && entries[i].eng == eng) begin
        @(posedge ap_clk);
        #drive_delay;
        drive_input(eng, entries[i], 1'b1);
        do begin
          @(posedge ap_clk);
        end while (!(eng ? in_ready_b : in_ready_a));
        #drive_delay;
        drive_input(eng, entries[i], 1'b0);
      end
    end
  endtask

  task automatic check_output(input logic eng, input engine_pkg::engine_packet_t got);
    expect_t e;
    string   name;
    name = eng ? "B" : "A";
    if ((eng ? exp_b.size() : exp_a.size()) == 0) begin
      $display("Engine %s delivered a packet that was never sent", name);
      error_count++;
    end else begin
      if (eng) e = exp_b.pop_front();
      else e = exp_a.pop_front();
      tests_run++;
      assert (got === e.pkt) begin
        $display("test %0d on engine %s done, packet matches", e.idx, name);
      end else begin
        $display("** Error at time %0t: test %0d on engine %s, got %h expected %h",
                 $time, e.idx, name, got, e.pkt);
        tests_failed++;
        error_count++;
      end
    end
  endtask

  always @(posedge ap_clk) begin
    if (rst_n && out_valid_a && out_ready_a) begin
      check_output(1'b0, pkt_out_a);
    end
    if (rst_n && out_valid_b && out_ready_b) begin
      check_output(1'b1, pkt_out_b);
    end
  end

  // Downstream readiness, random while an entry asks for stalls
  always @(posedge ap_clk) begin
    #drive_delay;
    rnd_word    = $random(seed);
    out_ready_a = !stall_a || rnd_word[0];
    out_ready_b = !stall_b || rnd_word[1];
  end

  // ------------------------------
  // Main sequence and watchdog
  // ------------------------------
  initial begin
    logic reset_ok;
    seed        = 32'hf063_72bf;
    ap_clk      = 1'b0;
    rst_n       = 1'b0;
    cfg_a       = '0;
    cfg_b       = '0;
    pkt_in_a    = '0;
    pkt_in_b    = '0;
    in_valid_a  = 1'b0;
    in_valid_b  = 1'b0;
    out_ready_a = 1'b0;
    out_ready_b = 1'b0;
    stall_a     = 1'b0;
    stall_b     = 1'b0;
    reset_ok    = 1'b1;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge ap_clk);
    #drive_delay;
    rst_n = 1'b1;
    // Nothing may come out before the first packet goes in
    repeat (5) begin
      @(posedge ap_clk);
      assert (out_valid_a === 1'b0 && out_valid_b === 1'b0) else begin
        $display("** Error at time %0t: out_valid high after reset with no input", $time);
        reset_ok = 1'b0;
      end
    end
    tests_run++;
    if (reset_ok) begin
      $display("reset test done, outputs stayed idle");
    end else begin
      tests_failed++;
      error_count++;
    end
    for (int g = 0; g <= last_group; g++) begin
      predict_group(g);
      fork
        stream(1'b0, g);
        stream(1'b1, g);
      join
      while (exp_a.size() != 0 || exp_b.size() != 0) begin
        @(posedge ap_clk);
      end
    end
    // Any packet delivered in this window is a duplicate
    repeat (8) @(posedge ap_clk);
    error_count += assertion_failures();
    $display("Tests run %0d, passed %0d, failed %0d, other errors %0d", tests_run,
             tests_run - tests_failed, tests_failed, error_count - tests_failed);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  initial begin
    wait (table_ready === 1'b1);
    #((entries.size() * 40 + 16) * period);
    $display("Timeout, packets still outstanding after %0d cycles",
             entries.size() * 40 + 16);
    $display("Result: FAILED");
    $finish;
  end

endmodule
